// File: src/vrc_irq_pkg.sv
`default_nettype none

package vrc_irq_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cpu register offsets, as wishbone word addresses.
    localparam logic [1:0] reg_latch = 2'd0;
    localparam logic [1:0] reg_ctrl  = 2'd1;
    localparam logic [1:0] reg_ack   = 2'd2;   // a read here returns the counter.

    // save-state addresses. anything else reads back as 0xFF.
    localparam logic [5:0] sst_status   = 6'd16;
    localparam logic [5:0] sst_latch    = 6'd17;
    localparam logic [5:0] sst_counter  = 6'd18;
    localparam logic [5:0] sst_presc_lo = 6'd19;
    localparam logic [5:0] sst_presc_hi = 6'd20;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one scanline is 341 cycles; the counter is clocked three times per line.
    localparam logic [8:0] presc_last   = 9'd340;
    localparam logic [8:0] presc_tick_a = 9'd113;
    localparam logic [8:0] presc_tick_b = 9'd227;

    // wishbone slave states.
    localparam logic [1:0] bus_idle    = 2'd0;
    localparam logic [1:0] bus_ack     = 2'd1;
    localparam logic [1:0] bus_release = 2'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the status byte, seen either as a cpu control write or as the
    // save-state status byte which also carries the pending flag.
    typedef union packed {
        struct packed {
            logic [4:0] unused;
            logic       mode;               // set selects cycle mode.
            logic       enable;
            logic       enable_after_ack;
        } cpu_ctrl;
        struct packed {
            logic [3:0] zero;
            logic       pending;
            logic       mode;
            logic       enable;
            logic       enable_after_ack;
        } sst_stat;
    } irq_status_u;

endpackage

`default_nettype wire

// File: src/vrc_bus_slave.sv
`timescale 1ns/10ps
`default_nettype none

module vrc_bus_slave
    import vrc_irq_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [7:0]  wb_dat_w,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack,

    input  logic [7:0]  latch_value,
    input  irq_status_u status_value,
    input  logic [7:0]  counter_value,

    output logic        wr_latch,
    output logic        wr_ctrl,
    output logic        wr_ack,
    output logic [7:0]  cpu_data
);

    logic [1:0]  state;
    logic [1:0]  adr_q;
    logic        start;
    irq_status_u ctrl_word;

    assign start  = wb_cyc && wb_stb;
    assign wb_ack = (state == bus_ack);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // idle -> ack -> (release) -> idle. each request gets exactly one ack.
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= bus_idle;
            wr_latch <= 1'b0;
            wr_ctrl  <= 1'b0;
            wr_ack   <= 1'b0;
        end else begin
            wr_latch <= 1'b0;
            wr_ctrl  <= 1'b0;
            wr_ack   <= 1'b0;
            case (state)
                bus_idle: begin
                    if (start) begin
                        state    <= bus_ack;
                        wr_latch <= wb_we && (wb_adr == reg_latch);
                        wr_ctrl  <= wb_we && (wb_adr == reg_ctrl);
                        wr_ack   <= wb_we && (wb_adr == reg_ack);
                    end
                end
                bus_ack: begin
                    // master still holding the strobe, so wait for it to drop.
                    state <= start ? bus_release : bus_idle;
                end
                bus_release: begin
                    if (!start) begin
                        state <= bus_idle;
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bus_idle && start) begin
            adr_q    <= wb_adr;
            cpu_data <= wb_dat_w;
        end
    end

    // control read shows only the three control bits.
    always_comb begin
        ctrl_word                           = '0;
        ctrl_word.cpu_ctrl.mode             = status_value.cpu_ctrl.mode;
        ctrl_word.cpu_ctrl.enable           = status_value.cpu_ctrl.enable;
        ctrl_word.cpu_ctrl.enable_after_ack = status_value.cpu_ctrl.enable_after_ack;
    end

    always_comb begin
        case (adr_q)
            reg_latch: wb_dat_r = latch_value;
            reg_ctrl:  wb_dat_r = ctrl_word;
            reg_ack:   wb_dat_r = counter_value;
            default:   wb_dat_r = 8'hFF;       // offset 3 is unused.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb));

    one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({wr_latch, wr_ctrl, wr_ack}));

endmodule

`default_nettype wire

// File: src/vrc_prescaler.sv
`timescale 1ns/10ps
`default_nettype none

module vrc_prescaler
    import vrc_irq_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       count_enable,
    input  logic       presc_clear,

    input  logic       sst_enable,
    input  logic       sst_we,
    input  logic [5:0] sst_addr,
    input  logic [7:0] sst_data_in,

    output logic       scanline_tick,
    output logic [8:0] presc_value
);

    logic [8:0] presc_next;

    // wraps at the end of each 341-cycle scanline.
    assign presc_next = (presc_value == presc_last) ? 9'd0 : presc_value + 9'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            presc_value <= 9'd0;
        end else if (sst_enable) begin
            if (sst_we && sst_addr == sst_presc_lo) begin
                presc_value[7:0] <= sst_data_in;
            end
            if (sst_we && sst_addr == sst_presc_hi) begin
                presc_value[8] <= sst_data_in[0];   // only bit 0 is kept.
            end
        end else if (presc_clear) begin
            presc_value <= 9'd0;                    // control write restarts the line.
        end else if (count_enable) begin
            presc_value <= presc_next;
        end
    end

    // three evenly spaced ticks per scanline.
    assign scanline_tick = (presc_value == presc_tick_a) ||
                           (presc_value == presc_tick_b) ||
                           (presc_value == presc_last);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // a save-state load can put the value out of range, so only the
    // counting path is held to the wrap limit.
    presc_in_range: assert property (@(posedge clk) disable iff (reset)
        (!sst_enable && presc_value <= presc_last) |=> (presc_value <= presc_last));

endmodule

`default_nettype wire

// File: src/vrc_irq_counter.sv
`timescale 1ns/10ps
`default_nettype none

module vrc_irq_counter
    import vrc_irq_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        wr_latch,
    input  logic        wr_ctrl,
    input  logic        wr_ack,
    input  logic [7:0]  cpu_data,

    input  logic        scanline_tick,
    input  logic [8:0]  presc_value,

    input  logic        sst_enable,
    input  logic        sst_we,
    input  logic [5:0]  sst_addr,
    input  logic [7:0]  sst_data_in,

    output logic        irq,
    output logic        count_enable,
    output logic        presc_clear,
    output logic [7:0]  latch_value,
    output irq_status_u status_value,
    output logic [7:0]  counter_value,
    output logic [7:0]  sst_data_out
);

    logic        mode;
    logic        enable;
    logic        enable_after_ack;
    logic        pending;
    logic        clock_event;
    irq_status_u ctrl_in;
    irq_status_u sst_in;

    assign ctrl_in = cpu_data;
    assign sst_in  = sst_data_in;

    // cycle mode clocks every cycle, scanline mode only on prescaler ticks.
    assign clock_event  = enable && (mode || scanline_tick);
    assign count_enable = enable;
    assign presc_clear  = wr_ctrl && ctrl_in.cpu_ctrl.enable && !sst_enable;

    assign irq = !(pending && enable);     // active low.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            mode             <= 1'b0;
            enable           <= 1'b0;
            enable_after_ack <= 1'b0;
            pending          <= 1'b0;
            latch_value      <= 8'd0;
            counter_value    <= 8'd0;
        end else if (sst_enable) begin
            // cpu strobes and counting are frozen during save state.
            if (sst_we && sst_addr == sst_status) begin
                pending          <= sst_in.sst_stat.pending;
                mode             <= sst_in.sst_stat.mode;
                enable           <= sst_in.sst_stat.enable;
                enable_after_ack <= sst_in.sst_stat.enable_after_ack;
            end
            if (sst_we && sst_addr == sst_latch) begin
                latch_value <= sst_data_in;
            end
            if (sst_we && sst_addr == sst_counter) begin
                counter_value <= sst_data_in;
            end
        end else begin
            if (clock_event) begin
                if (counter_value == 8'hFF) begin
                    counter_value <= latch_value;   // overflow reloads and flags.
                    pending       <= 1'b1;
                end else begin
                    counter_value <= counter_value + 8'd1;
                end
            end

            // register writes land after counting, so they win.
            if (wr_latch) begin
                latch_value <= cpu_data;
            end else if (wr_ctrl) begin
                pending          <= 1'b0;
                mode             <= ctrl_in.cpu_ctrl.mode;
                enable           <= ctrl_in.cpu_ctrl.enable;
                enable_after_ack <= ctrl_in.cpu_ctrl.enable_after_ack;
                if (ctrl_in.cpu_ctrl.enable) begin
                    counter_value <= latch_value;
                end
            end else if (wr_ack) begin
                pending <= 1'b0;
                enable  <= enable_after_ack;
            end
        end
    end

    always_comb begin
        status_value                           = '0;
        status_value.sst_stat.pending          = pending;
        status_value.sst_stat.mode             = mode;
        status_value.sst_stat.enable           = enable;
        status_value.sst_stat.enable_after_ack = enable_after_ack;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (sst_addr)
            sst_status:   sst_data_out = status_value;
            sst_latch:    sst_data_out = latch_value;
            sst_counter:  sst_data_out = counter_value;
            sst_presc_lo: sst_data_out = presc_value[7:0];
            sst_presc_hi: sst_data_out = {7'd0, presc_value[8]};
            default:      sst_data_out = 8'hFF;
        endcase
    end

    // the irq can only assert while enabled, after an overflow or a state load.
    irq_source: assert property (@(posedge clk) disable iff (reset)
        $fell(irq) |-> enable && ($past(sst_enable) || $past(counter_value == 8'hFF)));

endmodule

`default_nettype wire

// File: src/vrc_irq_top.sv
`timescale 1ns/10ps
`default_nettype none

module vrc_irq_top
    import vrc_irq_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_dat_w,
    output logic [7:0] wb_dat_r,
    output logic       wb_ack,

    input  logic       sst_enable,
    input  logic       sst_we,
    input  logic [5:0] sst_addr,
    input  logic [7:0] sst_data_in,
    output logic [7:0] sst_data_out,

    output logic       irq
);

    logic        wr_latch;
    logic        wr_ctrl;
    logic        wr_ack;
    logic [7:0]  cpu_data;
    logic [7:0]  latch_value;
    logic [7:0]  counter_value;
    irq_status_u status_value;
    logic        count_enable;
    logic        presc_clear;
    logic        scanline_tick;
    logic [8:0]  presc_value;

    vrc_bus_slave vrc_bus_slave_i (
        .clk           (clk),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .latch_value   (latch_value),
        .status_value  (status_value),
        .counter_value (counter_value),
        .wr_latch      (wr_latch),
        .wr_ctrl       (wr_ctrl),
        .wr_ack        (wr_ack),
        .cpu_data      (cpu_data)
    );

    vrc_prescaler vrc_prescaler_i (
        .clk           (clk),
        .reset         (reset),
        .count_enable  (count_enable),
        .presc_clear   (presc_clear),
        .sst_enable    (sst_enable),
        .sst_we        (sst_we),
        .sst_addr      (sst_addr),
        .sst_data_in   (sst_data_in),
        .scanline_tick (scanline_tick),
        .presc_value   (presc_value)
    );

    vrc_irq_counter vrc_irq_counter_i (
        .clk           (clk),
        .reset         (reset),
        .wr_latch      (wr_latch),
        .wr_ctrl       (wr_ctrl),
        .wr_ack        (wr_ack),
        .cpu_data      (cpu_data),
        .scanline_tick (scanline_tick),
        .presc_value   (presc_value),
        .sst_enable    (sst_enable),
        .sst_we        (sst_we),
        .sst_addr      (sst_addr),
        .sst_data_in   (sst_data_in),
        .irq           (irq),
        .count_enable  (count_enable),
        .presc_clear   (presc_clear),
        .latch_value   (latch_value),
        .status_value  (status_value),
        .counter_value (counter_value),
        .sst_data_out  (sst_data_out)
    );

endmodule

`default_nettype wire

// File: testbench/tb_vrc_irq.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vrc_irq
    import vrc_irq_pkg::*;
();

    logic       clk;
    logic       reset;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [1:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic [7:0] wb_dat_r;
    logic       wb_ack;
    logic       sst_enable;
    logic       sst_we;
    logic [5:0] sst_addr;
    logic [7:0] sst_data_in;
    logic [7:0] sst_data_out;
    logic       irq;

    integer seed;
    int     error_count;
    int     pass_count;
    int     cycle_count;
    int     ack_cycle;     // cycle_count at the last wb_ack seen.

    vrc_irq_top vrc_irq_top_i (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .sst_enable   (sst_enable),
        .sst_we       (sst_we),
        .sst_addr     (sst_addr),
        .sst_data_in  (sst_data_in),
        .sst_data_out (sst_data_out),
        .irq          (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        #100000;
        $display("simulation ran past its time limit, a wait must have hung");
        $display("Test failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            error_count++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic void print_test_result(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endfunction

    // returns at the falling edge inside the ack cycle.
    task automatic wait_for_ack(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wb_ack && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) begin
            $display("%s at offset %0d got no wb_ack within 16 cycles", what, wb_adr);
            error_count++;
        end
        ack_cycle = cycle_count;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [7:0] data);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_for_ack("write");
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [7:0] data);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_for_ack("read");
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic sst_write(input logic [5:0] addr, input logic [7:0] data);
        @(negedge clk);
        sst_enable  = 1'b1;
        sst_we      = 1'b1;
        sst_addr    = addr;
        sst_data_in = data;
        @(negedge clk);
        sst_we = 1'b0;
    endtask

    task automatic sst_read(input logic [5:0] addr, output logic [7:0] data);
        @(negedge clk);
        sst_enable = 1'b1;
        sst_we     = 1'b0;
        sst_addr   = addr;
        @(negedge clk);
        data = sst_data_out;
    endtask

    task automatic wait_for_irq(input int start, input int limit, output int elapsed);
        // a control write only lands at the edge after its ack.
        @(negedge clk);
        while (irq && cycle_count - start < limit) begin
            @(negedge clk);
        end
        elapsed = cycle_count - start;
        if (irq) begin
            $display("irq did not fall within %0d cycles", limit);
            error_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reset_values();
        logic [7:0] rd;
        int         errors_before;
        errors_before = error_count;
        check("irq", 32'(irq), 32'd1);
        wb_read(reg_latch, rd);
        check("latch read", 32'(rd), 32'h00);
        wb_read(reg_ctrl, rd);
        check("control read", 32'(rd), 32'h00);
        wb_read(reg_ack, rd);
        check("counter read", 32'(rd), 32'h00);
        wb_read(2'd3, rd);
        check("offset 3 read", 32'(rd), 32'hFF);
        print_test_result("reset", errors_before);
    endtask

    task automatic cycle_mode_irq();
        logic [7:0] rd;
        int         lat;
        int         cnt;
        int         start;
        int         elapsed;
        int         errors_before;
        errors_before = error_count;
        lat = $random(seed) & 'h7F;
        wb_write(reg_latch, 8'(lat));
        wb_write(reg_ctrl, 8'h06);          // enabled in cycle mode.
        start = ack_cycle;
        wb_read(reg_ack, rd);
        cnt = int'(rd);
        check("counter near latch", 32'(cnt >= lat && cnt <= lat + 3), 32'd1);
        wait_for_irq(start, 260 - lat, elapsed);
        check("irq high for 254 - L cycles", 32'(elapsed >= 254 - lat), 32'd1);
        wb_read(reg_ack, rd);
        cnt = int'(rd);
        check("counter after reload", 32'(cnt >= lat && cnt <= lat + 4), 32'd1);
        print_test_result("cycle mode", errors_before);
    endtask

    task automatic irq_acknowledge();
        logic [7:0] rd;
        int         elapsed;
        int         low_cycles;
        int         errors_before;
        errors_before = error_count;
        wb_write(reg_latch, 8'hF0);
        wb_write(reg_ctrl, 8'h07);
        wait_for_irq(ack_cycle, 40, elapsed);
        wb_write(reg_ack, 8'h00);
        @(negedge clk);
        check("irq after ack", 32'(irq), 32'd1);
        wb_read(reg_ctrl, rd);
        check("control after ack", 32'(rd), 32'h07);

        // without enable_after_ack the ack turns counting off.
        wb_write(reg_ctrl, 8'h06);
        wait_for_irq(ack_cycle, 40, elapsed);
        wb_write(reg_ack, 8'h00);
        wb_read(reg_ctrl, rd);
        check("control after ack", 32'(rd), 32'h04);
        low_cycles = 0;
        repeat (600) begin
            @(negedge clk);
            if (!irq) begin
                low_cycles++;
            end
        end
        check("irq low cycles while disabled", 32'(low_cycles), 32'd0);
        print_test_result("acknowledge", errors_before);
    endtask

    task automatic scanline_mode_irq();
        int elapsed;
        int errors_before;
        errors_before = error_count;
        wb_write(reg_latch, 8'hFD);
        wb_write(reg_ctrl, 8'h02);
        wait_for_irq(ack_cycle, 400, elapsed);
        check("irq after three scanline ticks", 32'(elapsed >= 341), 32'd1);
        wb_write(reg_ctrl, 8'h02);          // clears pending.
        @(negedge clk);
        check("irq after control write", 32'(irq), 32'd1);
        print_test_result("scanline mode", errors_before);
    endtask

    task automatic save_state_access();
        logic [7:0] vals [0:4];
        logic [7:0] masks [0:4];
        logic [7:0] rd;
        int         i;
        int         errors_before;
        errors_before = error_count;
        masks = '{8'h0F, 8'hFF, 8'hFF, 8'hFF, 8'h01};
        for (i = 0; i < 5; i++) begin
            vals[i] = 8'($random(seed));
            sst_write(sst_status + 6'(i), vals[i]);
        end
        for (i = 0; i < 5; i++) begin
            sst_read(sst_status + 6'(i), rd);
            check($sformatf("save-state address %0d", 16 + i), 32'(rd),
                  32'(vals[i] & masks[i]));
        end
        sst_read(6'd21, rd);
        check("save-state address 21", 32'(rd), 32'hFF);
        sst_write(sst_status, 8'h0A);       // pending and enable.
        @(negedge clk);
        sst_enable = 1'b0;
        @(negedge clk);
        check("irq after state load", 32'(irq), 32'd0);
        print_test_result("save state", errors_before);
    endtask

    task automatic held_strobe_write();
        logic [7:0] value;
        logic [7:0] rd;
        int         acks;
        int         strobes;
        int         waited;
        int         errors_before;
        errors_before = error_count;
        wb_write(reg_ctrl, 8'h00);
        value   = 8'($random(seed));
        acks    = 0;
        strobes = 0;
        waited  = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = reg_latch;
        wb_dat_w = value;
        while (acks == 0 && waited < 16) begin
            @(negedge clk);
            waited++;
            acks    += int'(wb_ack);
            strobes += int'(vrc_irq_top_i.wr_latch);
        end
        if (acks == 0) begin
            $display("held write got no wb_ack within 16 cycles");
            error_count++;
        end
        repeat (10) begin
            @(negedge clk);
            acks    += int'(wb_ack);
            strobes += int'(vrc_irq_top_i.wr_latch);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        repeat (2) begin
            @(negedge clk);
            acks += int'(wb_ack);
        end
        check("wb_ack pulses", 32'(acks), 32'd1);
        check("latch write strobes", 32'(strobes), 32'd1);
        wb_read(reg_latch, rd);
        check("latch after held write", 32'(rd), 32'(value));
        print_test_result("bus hold", errors_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed        = 63141;
        error_count = 0;
        pass_count  = 0;
        cycle_count = 0;
        ack_cycle   = 0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 2'd0;
        wb_dat_w    = 8'd0;
        sst_enable  = 1'b0;
        sst_we      = 1'b0;
        sst_addr    = 6'd0;
        sst_data_in = 8'd0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        reset_values();
        cycle_mode_irq();
        irq_acknowledge();
        scanline_mode_irq();
        save_state_access();
        held_strobe_write();

        $display("checks passed: %0d, failed: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/vrc_irq_pkg.sv
src/vrc_bus_slave.sv
src/vrc_prescaler.sv
src/vrc_irq_counter.sv
src/vrc_irq_top.sv
testbench/tb_vrc_irq.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_vrc_irq -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_vrc_irq)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
